// ==== logic/edu_core_pkg.sv ====
// Core widths, size and ALU codes, error codes, condition codes, instruction union
package edu_core_pkg;

	// ---------------------------------------------------------------------
	// Widths
	localparam int xlen       = 64;
	localparam int ilen       = 32;
	localparam int reg_addr_w = 5;
	localparam int err_w      = 4;
	localparam int size_w     = 2;

	// Access size, log2 of the byte count
	localparam logic [size_w-1:0] size_b   = 2'b00;
	localparam logic [size_w-1:0] size_h   = 2'b01;
	localparam logic [size_w-1:0] size_w32 = 2'b10;
	localparam logic [size_w-1:0] size_x   = 2'b11;

	// ALU commands
	localparam logic [1:0] alu_add = 2'b00;
	localparam logic [1:0] alu_and = 2'b01;
	localparam logic [1:0] alu_orr = 2'b10;
	localparam logic [1:0] alu_eor = 2'b11;

	// Execute output select
	localparam logic out_alu = 1'b0;
	localparam logic out_cnd = 1'b1;

	// Error indicator values
	localparam logic [err_w-1:0] err_none  = 4'h0;
	localparam logic [err_w-1:0] err_undef = 4'h1;
	localparam logic [err_w-1:0] err_shift = 4'h2;

	localparam logic [ilen-1:0]       inst_nop = 32'hd503_201f;
	// XZR, reads zero and drops writes
	localparam logic [reg_addr_w-1:0] zero_reg = 5'd31;

	// Fixed opcode fields of each format
	localparam logic [5:0] op_add_imm = 6'b100010;
	localparam logic [4:0] op_log_reg = 5'b01010;
	localparam logic [2:0] op_ldst_hi = 3'b111;
	localparam logic [1:0] op_ldst_lo = 2'b01;
	localparam logic [7:0] op_csel    = 8'b1101_0100;

	// Condition codes, low bit inverts the test
	localparam logic [3:0] cond_eq = 4'h0;
	localparam logic [3:0] cond_ne = 4'h1;
	localparam logic [3:0] cond_cs = 4'h2;
	localparam logic [3:0] cond_mi = 4'h4;
	localparam logic [3:0] cond_vs = 4'h6;
	localparam logic [3:0] cond_hi = 4'h8;
	localparam logic [3:0] cond_ge = 4'ha;
	localparam logic [3:0] cond_lt = 4'hb;
	localparam logic [3:0] cond_gt = 4'hc;
	localparam logic [3:0] cond_al = 4'he;

	// ---------------------------------------------------------------------
	// One instruction word, four format views
	typedef union packed {
		struct packed {
			logic sf, op, s;
			logic [5:0] opc;
			logic sh;
			logic [11:0] imm12;
			logic [4:0] rn, rd;
		} add_imm;
		struct packed {
			logic sf;
			logic [1:0] opc;
			logic [4:0] fixed;
			logic [1:0] shift;
			logic n;
			logic [4:0] rm;
			logic [5:0] imm6;
			logic [4:0] rn, rd;
		} log_reg;
		struct packed {
			logic [1:0] size;
			logic [2:0] fixed_hi;
			logic v;
			logic [1:0] fixed_lo, opc;
			logic [11:0] imm12;
			logic [4:0] rn, rt;
		} ldst_uoff;
		struct packed {
			logic sf, op, s;
			logic [7:0] fixed;
			logic [4:0] rm;
			logic [3:0] cond;
			logic [1:0] op2;
			logic [4:0] rn, rd;
		} csel;
	} inst_word_u;

endpackage

// ==== logic/inst_decoder.sv ====
// Instruction decoder for add immediate, logical register, load/store, CSEL and NOP
module inst_decoder (
	input  edu_core_pkg::inst_word_u             inst,
	output logic [edu_core_pkg::reg_addr_w-1:0]  rn_addr,
	output logic [edu_core_pkg::reg_addr_w-1:0]  rm_addr,
	output logic [edu_core_pkg::reg_addr_w-1:0]  rd_addr,
	output logic [edu_core_pkg::xlen-1:0]        imm,
	output logic                                 use_imm,
	output logic [1:0]                           alu_cmd,
	output logic                                 invert_b,
	output logic                                 full_width,
	output logic                                 set_flags,
	output logic [3:0]                           cond,
	output logic                                 out_sel,
	output logic                                 mem_read,
	output logic                                 mem_write,
	output logic [edu_core_pkg::size_w-1:0]      mem_size,
	output logic                                 mem_sign,
	output logic                                 load_full,
	output logic                                 reg_write,
	output logic [edu_core_pkg::err_w-1:0]       error
);
	import edu_core_pkg::*;

	logic ldst_form;
	logic ldst_legal;

	// Unsigned offset load/store skeleton, SIMD excluded
	assign ldst_form = inst.ldst_uoff.fixed_hi == op_ldst_hi && !inst.ldst_uoff.v
		&& inst.ldst_uoff.fixed_lo == op_ldst_lo;
	// PRFM and the wider signed loads into W are not in the subset
	assign ldst_legal = inst.ldst_uoff.opc[1] == 1'b0
		|| (inst.ldst_uoff.opc[0] == 1'b0 && inst.ldst_uoff.size != size_x)
		|| (inst.ldst_uoff.opc[0] == 1'b1 && inst.ldst_uoff.size[1] == 1'b0);

	always_comb begin
		// Safe defaults, nothing written and no memory access
		rn_addr    = zero_reg;
		rm_addr    = zero_reg;
		rd_addr    = zero_reg;
		imm        = '0;
		use_imm    = 1'b0;
		alu_cmd    = alu_add;
		invert_b   = 1'b0;
		full_width = 1'b1;
		set_flags  = 1'b0;
		cond       = cond_al;
		out_sel    = out_alu;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_size   = size_x;
		mem_sign   = 1'b0;
		load_full  = 1'b1;
		reg_write  = 1'b0;
		error      = err_none;

		if (inst == inst_nop) begin
			// Bubble through the pipe
		end else if (inst.add_imm.opc == op_add_imm) begin
			rn_addr    = inst.add_imm.rn;
			rd_addr    = inst.add_imm.rd;
			// Optional LSL #12 on the immediate
			imm        = xlen'(inst.add_imm.imm12) << (inst.add_imm.sh ? 12 : 0);
			use_imm    = 1'b1;
			invert_b   = inst.add_imm.op;
			set_flags  = inst.add_imm.s;
			full_width = inst.add_imm.sf;
			reg_write  = 1'b1;
		end else if (inst.log_reg.fixed == op_log_reg && !inst.log_reg.n
				&& inst.log_reg.opc != 2'b11) begin
			if (inst.log_reg.imm6 != '0) begin
				error = err_shift;
			end else begin
				rn_addr    = inst.log_reg.rn;
				rm_addr    = inst.log_reg.rm;
				rd_addr    = inst.log_reg.rd;
				// opc 00 AND, 01 ORR, 10 EOR
				alu_cmd    = inst.log_reg.opc + 2'd1;
				full_width = inst.log_reg.sf;
				reg_write  = 1'b1;
			end
		end else if (ldst_form && ldst_legal) begin
			rn_addr    = inst.ldst_uoff.rn;
			// Offset scaled by access size
			imm        = xlen'(inst.ldst_uoff.imm12) << inst.ldst_uoff.size;
			use_imm    = 1'b1;
			mem_size   = inst.ldst_uoff.size;
			if (inst.ldst_uoff.opc == 2'b00) begin
				// Store data rides on the M read port
				rm_addr   = inst.ldst_uoff.rt;
				mem_write = 1'b1;
			end else begin
				rd_addr   = inst.ldst_uoff.rt;
				mem_read  = 1'b1;
				mem_sign  = inst.ldst_uoff.opc[1];
				load_full = inst.ldst_uoff.opc != 2'b11;
			end
		end else if (inst.csel.fixed == op_csel && !inst.csel.op && !inst.csel.s
				&& inst.csel.op2 == 2'b00) begin
			rn_addr    = inst.csel.rn;
			rm_addr    = inst.csel.rm;
			rd_addr    = inst.csel.rd;
			cond       = inst.csel.cond;
			out_sel    = out_cnd;
			full_width = inst.csel.sf;
			reg_write  = 1'b1;
		end else begin
			error = err_undef;
		end
	end

endmodule

// ==== logic/register_file.sv ====
// General register file, X0 to X30, XZR reads zero, two read and two write ports
module register_file (
	input  logic                                clk,
	input  logic                                nreset,
	input  logic [edu_core_pkg::reg_addr_w-1:0] rn_addr,
	input  logic [edu_core_pkg::reg_addr_w-1:0] rm_addr,
	input  logic                                wr_en,
	input  logic [edu_core_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [edu_core_pkg::xlen-1:0]       wr_data,
	input  logic                                ld_en,
	input  logic [edu_core_pkg::reg_addr_w-1:0] ld_addr,
	input  logic [edu_core_pkg::xlen-1:0]       ld_data,
	output logic [edu_core_pkg::xlen-1:0]       rn_data,
	output logic [edu_core_pkg::xlen-1:0]       rm_data
);
	import edu_core_pkg::*;

	// One entry per index below XZR
	logic [xlen-1:0] regs [zero_reg];

	// Old value seen when read and write collide
	assign rn_data = (rn_addr == zero_reg) ? '0 : regs[rn_addr];
	assign rm_data = (rm_addr == zero_reg) ? '0 : regs[rm_addr];

	always_ff @(posedge clk) begin
		// Execute result port
		if (wr_en && wr_addr != zero_reg)
			regs[wr_addr] <= wr_data;
		// Load data port
		if (ld_en && ld_addr != zero_reg)
			regs[ld_addr] <= ld_data;
	end

	// Decode never issues both kinds of write for one instruction
	assert property (@(posedge clk) disable iff (!nreset)
		!(wr_en && ld_en && wr_addr == ld_addr && wr_addr != zero_reg))
		else $error("register_file: both write ports target one register");

endmodule

// ==== logic/execute_unit.sv ====
// Execute stage ALU, NZCV flags, condition check, PSTATE and result select
module execute_unit (
	input  logic                          clk,
	input  logic                          nreset,
	input  logic                          advance,
	input  logic [edu_core_pkg::xlen-1:0] op_n,
	input  logic [edu_core_pkg::xlen-1:0] op_m,
	input  logic [1:0]                    alu_cmd,
	input  logic                          invert_b,
	input  logic                          full_width,
	input  logic                          set_flags,
	input  logic [3:0]                    cond,
	input  logic                          out_sel,
	output logic [edu_core_pkg::xlen-1:0] result
);
	import edu_core_pkg::*;

	// NZCV from bit 3 down to bit 0
	logic [3:0]      pstate;
	logic [3:0]      flags;
	logic [xlen-1:0] op_b;
	logic [xlen:0]   sum_full;
	logic [32:0]     sum_half;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] sel_out;
	logic            base_match;
	logic            cond_match;

	// ---------------------------------------------------------------------
	// ALU
	assign op_b = invert_b ? ~op_m : op_m;
	// Carry in completes the two's complement for SUB
	assign sum_full = {1'b0, op_n} + {1'b0, op_b} + {{xlen{1'b0}}, invert_b};
	// Separate 32-bit sum for the W form carry
	assign sum_half = {1'b0, op_n[31:0]} + {1'b0, op_b[31:0]} + {32'b0, invert_b};

	always_comb begin
		case (alu_cmd)
			alu_add: alu_out = sum_full[xlen-1:0];
			alu_and: alu_out = op_n & op_b;
			alu_orr: alu_out = op_n | op_b;
			alu_eor: alu_out = op_n ^ op_b;
			default: alu_out = '0;
		endcase
	end

	always_comb begin
		if (full_width) begin
			flags[3] = alu_out[xlen-1];
			flags[2] = alu_out == '0;
			flags[1] = sum_full[xlen];
			flags[0] = op_n[xlen-1] == op_b[xlen-1] && sum_full[xlen-1] != op_n[xlen-1];
		end else begin
			flags[3] = alu_out[31];
			flags[2] = alu_out[31:0] == '0;
			flags[1] = sum_half[32];
			flags[0] = op_n[31] == op_b[31] && sum_half[31] != op_n[31];
		end
		// No carry or overflow out of logical ops
		if (alu_cmd != alu_add)
			flags[1:0] = 2'b00;
	end

	// ---------------------------------------------------------------------
	// Condition check against PSTATE
	always_comb begin
		case (cond[3:1])
			cond_eq[3:1]: base_match = pstate[2];
			cond_cs[3:1]: base_match = pstate[1];
			cond_mi[3:1]: base_match = pstate[3];
			cond_vs[3:1]: base_match = pstate[0];
			cond_hi[3:1]: base_match = pstate[1] & ~pstate[2];
			cond_ge[3:1]: base_match = pstate[3] == pstate[0];
			cond_gt[3:1]: base_match = pstate[3] == pstate[0] && !pstate[2];
			default:      base_match = 1'b1;
		endcase
	end

	// AL and NV both pass
	assign cond_match = (cond[3:1] == cond_al[3:1]) ? 1'b1 : base_match ^ cond[0];

	// Next instruction in execute sees the new flags
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset)
			pstate <= 4'h0;
		else if (advance && set_flags)
			pstate <= flags;
	end

	// ---------------------------------------------------------------------
	// Result select, W results zero extended
	assign sel_out = (out_sel == out_cnd) ? (cond_match ? op_n : op_m) : alu_out;
	assign result  = full_width ? sel_out : {{(xlen-32){1'b0}}, sel_out[31:0]};

endmodule

// ==== logic/edu_core.sv ====
// Five stage core top with fetch, pipeline registers, memory drive and load extension
module edu_core (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             clk_en,
	input  logic [edu_core_pkg::ilen-1:0]    imem_data,
	input  logic [edu_core_pkg::xlen-1:0]    dmem_rdata,
	output logic [edu_core_pkg::err_w-1:0]   error,
	output logic [edu_core_pkg::xlen-1:0]    imem_addr,
	output logic                             imem_en,
	output logic [edu_core_pkg::xlen-1:0]    dmem_addr,
	output logic [edu_core_pkg::xlen-1:0]    dmem_wdata,
	output logic [edu_core_pkg::size_w-1:0]  dmem_size,
	output logic                             dmem_read,
	output logic                             dmem_write
);
	import edu_core_pkg::*;

	logic nreset_sync, inst_valid, advance, stalled;
	logic [xlen-1:0] pc;
	logic [ilen-1:0] id_inst, id_hold;
	logic [xlen-1:0] wb_rdata, wb_rdata_hold, wb_load_data;
	// Decode stage
	logic [reg_addr_w-1:0] id_rn_addr, id_rm_addr, id_rd_addr;
	logic [xlen-1:0] id_imm, id_rn_data, id_rm_data;
	logic [1:0] id_alu_cmd;
	logic [3:0] id_cond;
	logic [size_w-1:0] id_mem_size;
	logic id_use_imm, id_invert_b, id_full_width, id_set_flags, id_out_sel;
	logic id_mem_read, id_mem_write, id_mem_sign, id_load_full, id_reg_write;
	// Execute stage
	logic [xlen-1:0] ex_op_n, ex_op_m, ex_store_data, ex_result;
	logic [1:0] ex_alu_cmd;
	logic [3:0] ex_cond;
	logic [size_w-1:0] ex_mem_size;
	logic [reg_addr_w-1:0] ex_rd_addr;
	logic ex_invert_b, ex_full_width, ex_set_flags, ex_out_sel, ex_mem_sign, ex_load_full;
	logic ex_reg_write, ex_mem_read, ex_mem_write;
	// Memory and writeback stages
	logic [xlen-1:0] mem_result, mem_store_data, wb_result;
	logic [size_w-1:0] mem_size, wb_size;
	logic [reg_addr_w-1:0] mem_rd_addr, wb_rd_addr;
	logic mem_sign, mem_load_full, mem_reg_write, mem_read, mem_write;
	logic wb_sign, wb_load_full, wb_reg_write, wb_read;

	// ---------------------------------------------------------------------
	// Reset sync, stall, PC
	assign advance   = clk_en && error == err_none && nreset_sync;
	assign imem_en   = nreset_sync;
	assign imem_addr = pc;

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			nreset_sync <= 1'b0;
			inst_valid  <= 1'b0;
			stalled     <= 1'b0;
			pc          <= '0;
		end else begin
			nreset_sync <= 1'b1;
			// ROM data valid one clock after the first enabled fetch
			inst_valid  <= nreset_sync;
			stalled     <= !advance;
			if (advance)
				pc <= pc + xlen'(4);
		end
	end

	// ROM and RAM keep reading while held, so the held words are kept here
	always_ff @(posedge clk) begin
		if (!advance) begin
			id_hold       <= id_inst;
			wb_rdata_hold <= wb_rdata;
		end
	end

	assign id_inst  = stalled ? id_hold : (inst_valid ? imem_data : inst_nop);
	assign wb_rdata = stalled ? wb_rdata_hold : dmem_rdata;

	// ---------------------------------------------------------------------
	// Decode, register read, execute
	inst_decoder u_dec (
		.inst(id_inst), .rn_addr(id_rn_addr), .rm_addr(id_rm_addr), .rd_addr(id_rd_addr),
		.imm(id_imm), .use_imm(id_use_imm), .alu_cmd(id_alu_cmd), .invert_b(id_invert_b),
		.full_width(id_full_width), .set_flags(id_set_flags), .cond(id_cond),
		.out_sel(id_out_sel), .mem_read(id_mem_read), .mem_write(id_mem_write),
		.mem_size(id_mem_size), .mem_sign(id_mem_sign), .load_full(id_load_full),
		.reg_write(id_reg_write), .error(error)
	);

	register_file u_rf (
		.clk(clk), .nreset(nreset), .rn_addr(id_rn_addr), .rm_addr(id_rm_addr),
		.wr_en(wb_reg_write && advance), .wr_addr(wb_rd_addr), .wr_data(wb_result),
		.ld_en(wb_read && advance), .ld_addr(wb_rd_addr), .ld_data(wb_load_data),
		.rn_data(id_rn_data), .rm_data(id_rm_data)
	);

	execute_unit u_exu (
		.clk(clk), .nreset(nreset), .advance(advance), .op_n(ex_op_n), .op_m(ex_op_m),
		.alu_cmd(ex_alu_cmd), .invert_b(ex_invert_b), .full_width(ex_full_width),
		.set_flags(ex_set_flags), .cond(ex_cond), .out_sel(ex_out_sel), .result(ex_result)
	);

	// ---------------------------------------------------------------------
	// Stage control, cleared on reset
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			{ex_reg_write, ex_mem_read, ex_mem_write, ex_set_flags} <= '0;
			{mem_reg_write, mem_read, mem_write} <= '0;
			{wb_reg_write, wb_read} <= '0;
		end else if (advance) begin
			{ex_reg_write, ex_mem_read, ex_mem_write} <= {id_reg_write, id_mem_read, id_mem_write};
			ex_set_flags <= id_set_flags;
			{mem_reg_write, mem_read, mem_write} <= {ex_reg_write, ex_mem_read, ex_mem_write};
			{wb_reg_write, wb_read} <= {mem_reg_write, mem_read};
		end
	end

	// Stage payload
	always_ff @(posedge clk) begin
		if (advance) begin
			ex_op_n        <= id_rn_data;
			// Immediate takes the M operand slot
			ex_op_m        <= id_use_imm ? id_imm : id_rm_data;
			ex_store_data  <= id_rm_data;
			ex_alu_cmd     <= id_alu_cmd;
			ex_invert_b    <= id_invert_b;
			ex_full_width  <= id_full_width;
			ex_cond        <= id_cond;
			ex_out_sel     <= id_out_sel;
			ex_mem_size    <= id_mem_size;
			ex_mem_sign    <= id_mem_sign;
			ex_load_full   <= id_load_full;
			ex_rd_addr     <= id_rd_addr;
			// Result doubles as the memory address
			mem_result     <= ex_result;
			mem_store_data <= ex_store_data;
			mem_size       <= ex_mem_size;
			mem_sign       <= ex_mem_sign;
			mem_load_full  <= ex_load_full;
			mem_rd_addr    <= ex_rd_addr;
			wb_result      <= mem_result;
			wb_size        <= mem_size;
			wb_sign        <= mem_sign;
			wb_load_full   <= mem_load_full;
			wb_rd_addr     <= mem_rd_addr;
		end
	end

	// ---------------------------------------------------------------------
	// Memory stage, address bus idle without an access
	assign dmem_addr  = (mem_read || mem_write) ? mem_result : '0;
	assign dmem_wdata = mem_store_data;
	assign dmem_size  = mem_size;
	assign dmem_read  = mem_read;
	assign dmem_write = mem_write;

	// Writeback load extension
	always_comb begin
		case (wb_size)
			size_b:   wb_load_data = {{(xlen-8){wb_sign & wb_rdata[7]}}, wb_rdata[7:0]};
			size_h:   wb_load_data = {{(xlen-16){wb_sign & wb_rdata[15]}}, wb_rdata[15:0]};
			size_w32: wb_load_data = {{(xlen-32){wb_sign & wb_rdata[31]}}, wb_rdata[31:0]};
			default:  wb_load_data = wb_rdata;
		endcase
		// W destination clears the upper half
		if (!wb_load_full)
			wb_load_data = {{(xlen-32){1'b0}}, wb_load_data[31:0]};
	end

	// Decode gives each instruction at most one memory direction
	assert property (@(posedge clk) disable iff (!nreset) !(dmem_read && dmem_write))
		else $error("edu_core: read and write strobes both high");

endmodule

// ==== testbench/edu_core_tb.sv ====
// Testbench for edu_core with ROM and RAM models, directed tests, compare tasks and watchdog
module edu_core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import edu_core_pkg::*;

	localparam int clk_period      = 10;
	localparam int watchdog_cycles = 2000;
	localparam int rom_words       = 1024;
	localparam int ram_bytes       = 8192;

	logic              clk;
	logic              nreset;
	logic              clk_en;
	logic [ilen-1:0]   imem_data;
	logic [xlen-1:0]   dmem_rdata;
	logic [err_w-1:0]  error;
	logic [xlen-1:0]   imem_addr;
	logic              imem_en;
	logic [xlen-1:0]   dmem_addr;
	logic [xlen-1:0]   dmem_wdata;
	logic [size_w-1:0] dmem_size;
	logic              dmem_read;
	logic              dmem_write;

	logic [ilen-1:0] rom [rom_words];
	logic [7:0]      ram [ram_bytes];
	int              prog_len;
	integer          seed;
	int              fail_count;

	// Store traffic seen on the bus, in order
	logic [xlen-1:0]   st_addr [$];
	logic [xlen-1:0]   st_data [$];
	logic [size_w-1:0] st_size [$];
	// Store traffic the program should produce
	logic [xlen-1:0]   exp_addr [$];
	logic [xlen-1:0]   exp_data [$];
	logic [size_w-1:0] exp_size [$];

	edu_core dut (
		.clk(clk), .nreset(nreset), .clk_en(clk_en), .imem_data(imem_data),
		.dmem_rdata(dmem_rdata), .error(error), .imem_addr(imem_addr), .imem_en(imem_en),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_size(dmem_size),
		.dmem_read(dmem_read), .dmem_write(dmem_write)
	);

	always #(clk_period / 2) clk = ~clk;

	// ---------------------------------------------------------------------
	// Memory models
	// Synchronous ROM, one clock of latency
	always @(posedge clk) begin
		if (imem_en)
			imem_data <= rom[imem_addr[11:2]];
	end

	// Byte RAM, raw read aligned to bit 0, write accepted on an advancing edge
	always @(posedge clk) begin
		if (dmem_read)
			dmem_rdata <= read_ram64(dmem_addr);
		if (nreset && dmem_write && clk_en) begin
			for (int i = 0; i < 8; i++)
				if (i < (1 << dmem_size))
					ram[13'(dmem_addr + i)] <= dmem_wdata[8*i +: 8];
			st_addr.push_back(dmem_addr);
			st_data.push_back(dmem_wdata);
			st_size.push_back(dmem_size);
		end
	end

	function automatic logic [xlen-1:0] read_ram64(input logic [xlen-1:0] addr);
		logic [xlen-1:0] r;
		for (int i = 0; i < 8; i++)
			r[8*i +: 8] = ram[13'(addr + i)];
		return r;
	endfunction

	task automatic write_ram64(input logic [xlen-1:0] addr, input logic [xlen-1:0] value);
		for (int i = 0; i < 8; i++)
			ram[13'(addr + i)] = value[8*i +: 8];
	endtask

	// Fill byte mixes every address bit
	task automatic fill_ram();
		for (int i = 0; i < ram_bytes; i++)
			ram[i] = 8'(i ^ (i >> 8) ^ 8'h5a);
	endtask

	// ---------------------------------------------------------------------
	// Instruction builders, through the union views
	function automatic inst_word_u arith_word(input logic sf, input logic sub,
			input logic set_nzcv, input logic sh, input logic [11:0] imm12,
			input logic [4:0] rn, input logic [4:0] rd);
		inst_word_u w;
		w = '0;
		w.add_imm.sf    = sf;
		w.add_imm.op    = sub;
		w.add_imm.s     = set_nzcv;
		w.add_imm.opc   = op_add_imm;
		w.add_imm.sh    = sh;
		w.add_imm.imm12 = imm12;
		w.add_imm.rn    = rn;
		w.add_imm.rd    = rd;
		return w;
	endfunction

	// Shift type and amount stay zero
	function automatic inst_word_u logic_word(input logic sf, input logic [1:0] opc,
			input logic [4:0] rm, input logic [4:0] rn, input logic [4:0] rd);
		inst_word_u w;
		w = '0;
		w.log_reg.sf    = sf;
		w.log_reg.opc   = opc;
		w.log_reg.fixed = op_log_reg;
		w.log_reg.rm    = rm;
		w.log_reg.rn    = rn;
		w.log_reg.rd    = rd;
		return w;
	endfunction

	// opc 00 store, 01 zero extend load, 10 sign extend to X, 11 sign extend to W
	function automatic inst_word_u mem_word(input logic [1:0] size, input logic [1:0] opc,
			input logic [11:0] imm12, input logic [4:0] rn, input logic [4:0] rt);
		inst_word_u w;
		w = '0;
		w.ldst_uoff.size     = size;
		w.ldst_uoff.fixed_hi = op_ldst_hi;
		w.ldst_uoff.fixed_lo = op_ldst_lo;
		w.ldst_uoff.opc      = opc;
		w.ldst_uoff.imm12    = imm12;
		w.ldst_uoff.rn       = rn;
		w.ldst_uoff.rt       = rt;
		return w;
	endfunction

	function automatic inst_word_u csel_word(input logic sf, input logic [4:0] rm,
			input logic [3:0] cond, input logic [4:0] rn, input logic [4:0] rd);
		inst_word_u w;
		w = '0;
		w.csel.sf    = sf;
		w.csel.fixed = op_csel;
		w.csel.rm    = rm;
		w.csel.cond  = cond;
		w.csel.rn    = rn;
		w.csel.rd    = rd;
		return w;
	endfunction

	// ---------------------------------------------------------------------
	// Expected values from the ISA rules
	function automatic logic [xlen-1:0] arith_result(input logic sf, input logic sub,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic [xlen-1:0] r;
		r = sub ? a - b : a + b;
		return sf ? r : {{(xlen-32){1'b0}}, r[31:0]};
	endfunction

	function automatic logic [xlen-1:0] logic_result(input logic sf, input logic [1:0] opc,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic [xlen-1:0] r;
		case (opc)
			2'b00:   r = a & b;
			2'b01:   r = a | b;
			default: r = a ^ b;
		endcase
		return sf ? r : {{(xlen-32){1'b0}}, r[31:0]};
	endfunction

	// Flags of a 64-bit compare a minus b, then the condition test
	function automatic logic cond_holds(input logic [3:0] cond, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b);
		logic [xlen:0] diff;
		logic n, z, c, v;
		diff = {1'b0, a} + {1'b0, ~b} + 1;
		n = diff[xlen-1];
		z = diff[xlen-1:0] == '0;
		c = diff[xlen];
		v = a[xlen-1] != b[xlen-1] && diff[xlen-1] != a[xlen-1];
		case (cond)
			cond_eq: return z;
			cond_ne: return !z;
			cond_cs: return c;
			cond_lt: return n != v;
			cond_gt: return !z && n == v;
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [xlen-1:0] size_mask(input logic [size_w-1:0] size);
		return (size == size_x) ? '1 : (xlen'(1) << (8 << size)) - 1;
	endfunction

	function automatic logic [xlen-1:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// ---------------------------------------------------------------------
	// Compare tasks
	task automatic report_failure();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_data(input logic [xlen-1:0] got, input logic [xlen-1:0] expected,
			input string what);
		if (got !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			fail_count++;
			report_failure();
		end
	endtask

	task automatic check_size(input logic [size_w-1:0] got,
			input logic [size_w-1:0] expected, input string what);
		if (got !== expected) begin
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			fail_count++;
			report_failure();
		end
	endtask

	task automatic check_error(input logic [err_w-1:0] got, input logic [err_w-1:0] expected,
			input string what);
		if (got !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			fail_count++;
			report_failure();
		end
	endtask

	task automatic check_flag(input logic got, input logic expected, input string what);
		if (got !== expected) begin
			$display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, expected);
			fail_count++;
			report_failure();
		end
	endtask

	// ---------------------------------------------------------------------
	// Program loading and run control
	// Reset held while ROM, RAM and logs are set up
	task automatic begin_test();
		@(negedge clk);
		nreset = 1'b0;
		clk_en = 1'b1;
		for (int i = 0; i < rom_words; i++)
			rom[i] = inst_nop;
		fill_ram();
		prog_len = 0;
		st_addr.delete();
		st_data.delete();
		st_size.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_size.delete();
	endtask

	task automatic release_reset();
		repeat (8) @(negedge clk);
		// Fetch and data strobes idle under reset
		check_flag(imem_en, 1'b0, "imem_en in reset");
		check_flag(dmem_read, 1'b0, "dmem_read in reset");
		check_flag(dmem_write, 1'b0, "dmem_write in reset");
		nreset = 1'b1;
		// Fetch enabled once the synchronizer cycle has passed
		@(negedge clk);
		check_flag(imem_en, 1'b1, "imem_en after reset sync");
	endtask

	// Three NOPs after each instruction cover the missing forwarding
	task automatic put_inst(input logic [ilen-1:0] w);
		rom[prog_len] = w;
		prog_len += 4;
	endtask

	task automatic put_store(input logic [size_w-1:0] size, input logic [11:0] imm12,
			input logic [4:0] rn, input logic [4:0] rt, input logic [xlen-1:0] base,
			input logic [xlen-1:0] data);
		put_inst(mem_word(size, 2'b00, imm12, rn, rt));
		// Offset scaled by the access size
		exp_addr.push_back(base + (xlen'(imm12) << size));
		exp_data.push_back(data & size_mask(size));
		exp_size.push_back(size);
	endtask

	// Operand words live at slot times 8, read with LDR X off XZR
	task automatic load_operand(input logic [11:0] slot, input logic [4:0] rt,
			input logic [xlen-1:0] value);
		write_ram64(xlen'(slot) << 3, value);
		put_inst(mem_word(size_x, 2'b01, slot, zero_reg, rt));
	endtask

	task automatic wait_stores();
		while (st_addr.size() < exp_addr.size())
			@(negedge clk);
		// Extra cycles expose any surplus store
		repeat (10) @(negedge clk);
	endtask

	task automatic compare_stores();
		check_data(xlen'(st_addr.size()), xlen'(exp_addr.size()), "number of stores");
		foreach (exp_addr[i]) begin
			check_data(st_addr[i], exp_addr[i], "store address");
			check_data(st_data[i] & size_mask(exp_size[i]), exp_data[i], "store data");
			check_size(st_size[i], exp_size[i], "store size");
		end
	endtask

	task automatic finish_program();
		release_reset();
		wait_stores();
		compare_stores();
		check_error(error, err_none, "error output");
	endtask

	// Random clk_en low spans once the program is running
	task automatic drive_stalls();
		int run_len;
		int hold_len;
		repeat (12) @(negedge clk);
		repeat (5) begin
			run_len  = 2 + ({$random(seed)} % 8);
			hold_len = 1 + ({$random(seed)} % 6);
			clk_en = 1'b0;
			repeat (hold_len) @(negedge clk);
			clk_en = 1'b1;
			repeat (run_len) @(negedge clk);
		end
	endtask

	// ---------------------------------------------------------------------
	// Directed tests
	task automatic arith_imm_test();
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [11:0]     imm12;
		logic            sh;
		begin_test();
		a = rand64();
		load_operand(12'd0, 5'd1, a);
		for (int sf = 0; sf < 2; sf++) begin
			// Bit 0 subtracts, bit 1 sets flags
			for (int kind = 0; kind < 4; kind++) begin
				imm12 = 12'($random(seed));
				sh    = 1'($random(seed));
				b     = xlen'(imm12) << (sh ? 12 : 0);
				put_inst(arith_word(1'(sf), kind[0], kind[1], sh, imm12, 5'd1, 5'd2));
				put_store(size_x, 12'(64 + sf * 4 + kind), zero_reg, 5'd2, '0,
					arith_result(1'(sf), kind[0], a, b));
			end
		end
		finish_program();
	endtask

	task automatic logic_reg_test();
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		begin_test();
		a = rand64();
		b = rand64();
		load_operand(12'd0, 5'd1, a);
		load_operand(12'd1, 5'd2, b);
		for (int sf = 0; sf < 2; sf++) begin
			for (int opc = 0; opc < 3; opc++) begin
				put_inst(logic_word(1'(sf), 2'(opc), 5'd2, 5'd1, 5'd3));
				put_store(size_x, 12'(64 + sf * 3 + opc), zero_reg, 5'd3, '0,
					logic_result(1'(sf), 2'(opc), a, b));
			end
		end
		finish_program();
	endtask

	// Equal, lower and higher compare for every condition
	task automatic csel_test();
		logic [3:0]      conds [5] = '{cond_eq, cond_ne, cond_cs, cond_lt, cond_gt};
		logic [xlen-1:0] p;
		logic [xlen-1:0] q;
		logic [11:0]     v;
		logic [11:0]     delta;
		logic [11:0]     imm;
		begin_test();
		p = rand64();
		q = rand64();
		load_operand(12'd0, 5'd4, p);
		load_operand(12'd1, 5'd5, q);
		for (int c = 0; c < 3; c++) begin
			v     = 12'(100 + {$random(seed)} % 3000);
			delta = 12'(1 + {$random(seed)} % 50);
			case (c)
				0:       imm = v;
				1:       imm = v + delta;
				default: imm = v - delta;
			endcase
			put_inst(arith_word(1'b1, 1'b0, 1'b0, 1'b0, v, zero_reg, 5'd1));
			put_inst(arith_word(1'b1, 1'b1, 1'b1, 1'b0, imm, 5'd1, 5'd3));
			for (int k = 0; k < 5; k++) begin
				put_inst(csel_word(1'b1, 5'd5, conds[k], 5'd4, 5'd6));
				put_store(size_x, 12'(64 + c * 5 + k), zero_reg, 5'd6, '0,
					cond_holds(conds[k], xlen'(v), xlen'(imm)) ? p : q);
			end
		end
		finish_program();
	endtask

	task automatic store_size_test();
		logic [xlen-1:0] x;
		logic [11:0]     base;
		logic [11:0]     byte_off;
		logic [7:0]      b8;
		begin_test();
		x        = rand64();
		base     = 12'(256 + {$random(seed)} % 256);
		byte_off = 12'({$random(seed)} % 256);
		// Negative byte so sign and zero extension differ
		b8       = 8'($random(seed)) | 8'h80;
		ram[2048 + byte_off] = b8;
		load_operand(12'd0, 5'd1, x);
		put_inst(arith_word(1'b1, 1'b0, 1'b0, 1'b0, base, zero_reg, 5'd7));
		put_inst(arith_word(1'b1, 1'b0, 1'b0, 1'b0, 12'd2048, zero_reg, 5'd10));
		for (int s = 0; s < 4; s++)
			put_store(2'(s), 12'({$random(seed)} % 64), 5'd7, 5'd1, xlen'(base), x);
		// LDRSB X8, LDRB X9, LDRSB W11
		put_inst(mem_word(size_b, 2'b10, byte_off, 5'd10, 5'd8));
		put_inst(mem_word(size_b, 2'b01, byte_off, 5'd10, 5'd9));
		put_inst(mem_word(size_b, 2'b11, byte_off, 5'd10, 5'd11));
		put_store(size_x, 12'd200, zero_reg, 5'd8, '0, {{(xlen-8){b8[7]}}, b8});
		put_store(size_x, 12'd201, zero_reg, 5'd9, '0, {{(xlen-8){1'b0}}, b8});
		put_store(size_x, 12'd202, zero_reg, 5'd11, '0, {32'b0, {24{b8[7]}}, b8});
		finish_program();
	endtask

	task automatic stall_test();
		logic [xlen-1:0] a;
		logic [11:0]     imm12;
		begin_test();
		a = rand64();
		load_operand(12'd0, 5'd1, a);
		for (int k = 0; k < 8; k++) begin
			imm12 = 12'($random(seed));
			put_inst(arith_word(1'b1, 1'b0, 1'b0, 1'b0, imm12, 5'd1, 5'd2));
			put_store(size_x, 12'(64 + k), zero_reg, 5'd2, '0, a + xlen'(imm12));
		end
		release_reset();
		fork
			drive_stalls();
			wait_stores();
		join
		compare_stores();
		check_error(error, err_none, "error output");
	endtask

	// Core freezes on the bad word, the store behind it never reaches the bus
	task automatic undef_test();
		logic [11:0] v;
		begin_test();
		v = 12'($random(seed));
		put_inst(arith_word(1'b1, 1'b0, 1'b0, 1'b0, v, zero_reg, 5'd2));
		put_store(size_x, 12'd64, zero_reg, 5'd2, '0, xlen'(v));
		put_inst(32'h0000_0000);
		put_inst(mem_word(size_x, 2'b00, 12'd65, zero_reg, 5'd2));
		release_reset();
		while (error == err_none)
			@(negedge clk);
		repeat (20) @(negedge clk);
		check_error(error, err_undef, "error after undefined encoding");
		compare_stores();
	endtask

	// ---------------------------------------------------------------------
	// Main sequence and watchdog
	initial begin
		seed       = 32'h4901_fc88;
		fail_count = 0;
		prog_len   = 0;
		clk        = 1'b0;
		nreset     = 1'b0;
		clk_en     = 1'b0;
		imem_data  = inst_nop;
		dmem_rdata = '0;
		arith_imm_test();
		logic_reg_test();
		csel_test();
		store_size_test();
		stall_test();
		undef_test();
		if (fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			report_failure();
		end
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
		report_failure();
	end

endmodule

// ==== edu_core.f ====
logic/edu_core_pkg.sv
logic/inst_decoder.sv
logic/register_file.sv
logic/execute_unit.sv
logic/edu_core.sv
testbench/edu_core_tb.sv

// ==== Bender.yml ====
package:
  name: edu_core

sources:
  - logic/edu_core_pkg.sv
  - logic/inst_decoder.sv
  - logic/register_file.sv
  - logic/execute_unit.sv
  - logic/edu_core.sv
  - target: test
    files:
      - testbench/edu_core_tb.sv
